/* rk_loader_top.f */
design/rk_loader_pkg.sv
design/rk_stream_parser.sv
design/ram_clear_sequencer.sv
design/program_ram.sv
design/rk_loader_top.sv
testbench/rk_loader_assert.sv
testbench/rk_loader_tb.sv

/* Bender.yml */
package:
  name: rk_loader

sources:
  - files:
      - design/rk_loader_pkg.sv
      - design/rk_stream_parser.sv
      - design/ram_clear_sequencer.sv
      - design/program_ram.sv
      - design/rk_loader_top.sv
  - target: test
    files:
      - testbench/rk_loader_assert.sv
      - testbench/rk_loader_tb.sv

/* testbench/rk_loader_tb.sv */
// Testbench for the RK program loader.
// Each table case streams one tape file, waits for busy_o to fall and reads
// all 64 KiB back against a model built from the RK format rules.
// A held case opens the next download during its clear and is not read back.
// The clear walks nearly the whole RAM, so one case takes about 330k cycles.
// Start addresses stay above the stub and no image wraps past 16'hFFFF.

`timescale 1ns/1ps

module rk_loader_tb
	import rk_loader_pkg::*;
();

	localparam int NUM_CASES = 4;
	localparam logic [DATA_W-1:0] SYNC_BYTE = 8'hE6;
	// Reset, power-up readback and one full readback per case
	localparam int MARGIN_CYCLES = (NUM_CASES + 1) * RAM_WORDS + 10000;

	// --------------------------------------------------
	// Load cases
	// --------------------------------------------------
	string case_name [NUM_CASES] = '{
		"stub_idx02", "data_idx41", "clear_shorter", "low_start_idx01"
	};
	logic [DATA_W-1:0]     case_index [NUM_CASES] = '{8'h02, 8'h41, 8'h02, 8'h01};
	logic [RAM_ADDR_W-1:0] case_start [NUM_CASES] = '{16'h4000, 16'hF0F0, 16'hF0F0, 16'h0003};
	int                    case_len   [NUM_CASES] = '{48, 40, 12, 20};
	logic [31:0]           case_seed  [NUM_CASES] = '{32'h11, 32'h22, 32'h33, 32'h44};
	// Offer the next case's first byte while this case clears
	bit                    case_hold  [NUM_CASES] = '{1'b1, 1'b0, 1'b0, 1'b0};

	logic                  clk_sys = 1'b0;
	logic                  reset_key;
	logic                  dl_active;
	logic [DATA_W-1:0]     dl_index;
	logic                  dl_valid;
	logic [DATA_W-1:0]     dl_data;
	logic                  dl_ready;
	logic [RAM_ADDR_W-1:0] rd_addr;
	logic [DATA_W-1:0]     rd_data;
	logic                  busy;

	logic [DATA_W-1:0] model [RAM_WORDS];
	logic [DATA_W-1:0] stream [$];
	integer            seed;
	int                errors;
	int                checks;
	int                cycles;
	int                cycle_limit;

	rk_loader_top DUT (
		.clk_sys     (clk_sys),
		.reset_key   (reset_key),
		.dl_active_i (dl_active),
		.dl_index_i  (dl_index),
		.dl_valid_i  (dl_valid),
		.dl_data_i   (dl_data),
		.dl_ready_o  (dl_ready),
		.rd_addr_i   (rd_addr),
		.rd_data_o   (rd_data),
		.busy_o      (busy)
	);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("TIMEOUT after %0d cycles, %0d errors so far", cycles, errors);
			$display("sim failed");
			$finish;
		end
	end

	function automatic bit skips_sync(input logic [DATA_W-1:0] idx);
		return (idx == SYNC_SKIP_INDEX_A) || (idx == SYNC_SKIP_INDEX_B);
	endfunction

	function automatic logic [DATA_W-1:0] first_byte(input int c);
		return skips_sync(case_index[c]) ? case_start[c][15:8] : SYNC_BYTE;
	endfunction

	// Header is sync, start hi, start lo, end hi, end lo
	task automatic build_stream(input int c);
		logic [RAM_ADDR_W-1:0] last;
		stream.delete();
		last = RAM_ADDR_W'(case_start[c] + case_len[c] - 1);
		if (!skips_sync(case_index[c]))
			stream.push_back(SYNC_BYTE);
		stream.push_back(case_start[c][15:8]);
		stream.push_back(case_start[c][7:0]);
		stream.push_back(last[15:8]);
		stream.push_back(last[7:0]);
		seed = seed ^ case_seed[c];
		for (int k = 0; k < case_len[c]; k++)
			stream.push_back(DATA_W'($random(seed)));
	endtask

	task automatic update_model(input int c);
		int                    base;
		logic [RAM_ADDR_W-1:0] addr;
		base = stream.size() - case_len[c];
		model[0] = JMP_OPCODE;
		model[1] = case_start[c][7:0];
		model[STUB_LAST_ADDR] = case_start[c][15:8];
		for (int k = 0; k < case_len[c]; k++)
			model[RAM_ADDR_W'(case_start[c] + k)] = stream[base + k];
		// Clear from after the last data byte up to one below the start
		addr = RAM_ADDR_W'(case_start[c] + case_len[c]);
		while (addr != case_start[c]) begin
			if (addr > STUB_LAST_ADDR)
				model[addr] = '0;
			addr = addr + 1'b1;
		end
	endtask

	// First byte goes out with dl_active rising, later ones after random gaps
	task automatic send_stream();
		int gap;
		for (int i = 0; i < stream.size(); i++) begin
			if (i > 0) begin
				gap = $unsigned($random(seed)) % 3;
				dl_valid = 1'b0;
				repeat (gap) begin
					@(posedge clk_sys);
					#2;
				end
			end
			dl_active = 1'b1;
			dl_valid  = 1'b1;
			dl_data   = stream[i];
			while (!dl_ready) begin
				@(posedge clk_sys);
				#2;
			end
			@(posedge clk_sys);
			#2;
		end
		dl_valid  = 1'b0;
		dl_active = 1'b0;
	endtask

	// Opens the next download while this case clears
	task automatic hold_during_clear(input int c);
		while (dl_ready) begin
			@(posedge clk_sys);
			#2;
		end
		dl_index  = case_index[c + 1];
		dl_active = 1'b1;
		dl_valid  = 1'b1;
		dl_data   = first_byte(c + 1);
		while (!dl_ready) begin
			checks++;
			if (!busy) begin
				errors++;
				$display("CHECK FAILED %s busy_o expected 1 actual %b", case_name[c], busy);
			end
			@(posedge clk_sys);
			#2;
		end
		// Still offered, so it transfers as the first byte of the next download
	endtask

	task automatic wait_idle();
		while (busy) begin
			@(posedge clk_sys);
			#2;
		end
	endtask

	task automatic check_ram(input string name);
		for (int a = 0; a < RAM_WORDS; a++) begin
			rd_addr = RAM_ADDR_W'(a);
			@(posedge clk_sys);
			#2;
			checks++;
			if (rd_data !== model[a]) begin
				errors++;
				$display("CHECK FAILED %s addr %h expected %h actual %h",
					name, RAM_ADDR_W'(a), model[a], rd_data);
			end
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		seed      = 32'h4d16_5fcf;
		errors    = 0;
		checks    = 0;
		cycles    = 0;
		reset_key = 1'b1;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_valid  = 1'b0;
		dl_data   = '0;
		rd_addr   = '0;
		for (int a = 0; a < RAM_WORDS; a++)
			model[a] = '0;
		cycle_limit = 16 + MARGIN_CYCLES;
		for (int c = 0; c < NUM_CASES; c++)
			cycle_limit += 3 * (HDR_LEN + case_len[c]) + RAM_WORDS * ERASE_STEP_CYCLES;

		repeat (16) @(posedge clk_sys);
		#2;
		reset_key = 1'b0;
		@(posedge clk_sys);
		#2;
		checks += 2;
		if (busy !== 1'b0) begin
			errors++;
			$display("CHECK FAILED after_reset busy_o expected 0 actual %b", busy);
		end
		if (dl_ready !== 1'b1) begin
			errors++;
			$display("CHECK FAILED after_reset dl_ready_o expected 1 actual %b", dl_ready);
		end
		check_ram("power_up");

		for (int c = 0; c < NUM_CASES; c++) begin
			dl_index = case_index[c];
			build_stream(c);
			update_model(c);
			send_stream();
			if (case_hold[c] && c + 1 < NUM_CASES) begin
				// Next download is already open, so busy_o stays high
				hold_during_clear(c);
			end else begin
				wait_idle();
				check_ram(case_name[c]);
			end
		end

		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* testbench/rk_loader_assert.sv */
// Concurrent checks on the download handshake, RAM port use and the busy flag.
// Bound into rk_loader_top; reset is synchronous and active high.

`timescale 1ns/1ps

module rk_loader_assert
	import rk_loader_pkg::*;
(
	input logic              clk_sys,
	input logic              reset_key,
	input logic              dl_active_i,
	input logic              dl_valid_i,
	input logic [DATA_W-1:0] dl_data_i,
	input logic              dl_ready_i,
	input logic              clearing_i,
	input logic              ld_we_i,
	input logic              busy_i
);

	logic seen_active;

	// Set once the first download begins
	always_ff @(posedge clk_sys) begin
		if (reset_key)
			seen_active <= 1'b0;
		else if (dl_active_i)
			seen_active <= 1'b1;
	end

	data_held: assert property (@(posedge clk_sys) disable iff (reset_key)
		dl_valid_i && !dl_ready_i |=> $stable(dl_data_i))
		else $error("dl_data_i changed while a byte waited for dl_ready_o");

	no_load_write_in_clear: assert property (@(posedge clk_sys) disable iff (reset_key)
		clearing_i |-> !ld_we_i)
		else $error("parser write issued during the RAM clear");

	idle_after_reset: assert property (@(posedge clk_sys) disable iff (reset_key)
		!seen_active |-> !busy_i)
		else $error("busy_o high before any download started");

endmodule

bind rk_loader_top rk_loader_assert u_assert (
	.clk_sys     (clk_sys),
	.reset_key   (reset_key),
	.dl_active_i (dl_active_i),
	.dl_valid_i  (dl_valid_i),
	.dl_data_i   (dl_data_i),
	.dl_ready_i  (dl_ready_o),
	.clearing_i  (clearing),
	.ld_we_i     (ld_we),
	.busy_i      (busy_o)
);

/* design/rk_loader_top.sv */
// RK program loader top. Parser and clear sequencer both feed RAM writes,
// program_ram merges them onto its single port.
// The host read port is valid only while busy_o is low.

`timescale 1ns/1ps

module rk_loader_top
	import rk_loader_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset_key,
	input  logic                  dl_active_i,
	input  logic [DATA_W-1:0]     dl_index_i,
	input  logic                  dl_valid_i,
	input  logic [DATA_W-1:0]     dl_data_i,
	output logic                  dl_ready_o,
	input  logic [RAM_ADDR_W-1:0] rd_addr_i,
	output logic [DATA_W-1:0]     rd_data_o,
	output logic                  busy_o
);

	logic                  ld_we;
	logic [RAM_ADDR_W-1:0] ld_addr;
	logic [DATA_W-1:0]     ld_data;
	logic [RAM_ADDR_W-1:0] last_addr;
	start_addr_u           start_addr;
	logic                  load_done;
	logic                  loading;
	logic                  clearing;
	logic                  clr_we;
	logic [RAM_ADDR_W-1:0] clr_addr;

	// --------------------------------------------------
	// Stream parser
	// --------------------------------------------------
	rk_stream_parser u_parser (
		.clk_sys      (clk_sys),
		.reset_key    (reset_key),
		.dl_active_i  (dl_active_i),
		.dl_index_i   (dl_index_i),
		.dl_valid_i   (dl_valid_i),
		.dl_data_i    (dl_data_i),
		.clearing_i   (clearing),
		.dl_ready_o   (dl_ready_o),
		.ld_we_o      (ld_we),
		.load_done_o  (load_done),
		.loading_o    (loading),
		.ld_addr_o    (ld_addr),
		.last_addr_o  (last_addr),
		.ld_data_o    (ld_data),
		.start_addr_o (start_addr)
	);

	// Clear of the unused RAM
	ram_clear_sequencer u_clear (
		.clk_sys      (clk_sys),
		.reset_key    (reset_key),
		.load_done_i  (load_done),
		.start_addr_i (start_addr),
		.last_addr_i  (last_addr),
		.clearing_o   (clearing),
		.clr_we_o     (clr_we),
		.clr_addr_o   (clr_addr)
	);

	program_ram u_ram (
		.clk_sys    (clk_sys),
		.reset_key  (reset_key),
		.loading_i  (loading),
		.clearing_i (clearing),
		.ld_we_i    (ld_we),
		.clr_we_i   (clr_we),
		.ld_addr_i  (ld_addr),
		.clr_addr_i (clr_addr),
		.rd_addr_i  (rd_addr_i),
		.ld_data_i  (ld_data),
		.rd_data_o  (rd_data_o),
		.busy_o     (busy_o)
	);

endmodule

/* design/program_ram.sv */
// 64 KiB program RAM with one write port shared by loader and clear.
// Parser writes win while loading, clear writes otherwise; clears write zero.
// Host reads are registered and return zero while busy_o is high.
// Contents power up as zero.

`timescale 1ns/1ps

module program_ram
	import rk_loader_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset_key,
	input  logic                  loading_i,
	input  logic                  clearing_i,
	input  logic                  ld_we_i,
	input  logic                  clr_we_i,
	input  logic [RAM_ADDR_W-1:0] ld_addr_i,
	input  logic [RAM_ADDR_W-1:0] clr_addr_i,
	input  logic [RAM_ADDR_W-1:0] rd_addr_i,
	input  logic [DATA_W-1:0]     ld_data_i,
	output logic [DATA_W-1:0]     rd_data_o,
	output logic                  busy_o
);

	logic [DATA_W-1:0]     mem [RAM_WORDS];
	logic                  wr_en;
	logic [RAM_ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0]     wr_data;
	logic [DATA_W-1:0]     rd_q;

	initial begin
		for (int i = 0; i < RAM_WORDS; i++)
			mem[i] = '0;
	end

	// Write port select
	assign wr_en   = loading_i ? ld_we_i : clr_we_i;
	assign wr_addr = loading_i ? ld_addr_i : clr_addr_i;
	assign wr_data = loading_i ? ld_data_i : '0;

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_q <= mem[rd_addr_i];
	end

	always_ff @(posedge clk_sys) begin
		if (reset_key)
			busy_o <= 1'b0;
		else
			busy_o <= loading_i | clearing_i;
	end

	assign rd_data_o = busy_o ? '0 : rd_q;

endmodule

/* design/ram_clear_sequencer.sv */
// RAM clear after a download. Walks from the byte after the last one
// written, with 16-bit wrap, up to one below the start address.
// Addresses 0 to 2 hold the jump stub and are never written.
// One step every ERASE_STEP_CYCLES cycles, so run time depends on the image.

`timescale 1ns/1ps

module ram_clear_sequencer
	import rk_loader_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset_key,
	input  logic                  load_done_i,
	input  start_addr_u           start_addr_i,
	input  logic [RAM_ADDR_W-1:0] last_addr_i,
	output logic                  clearing_o,
	output logic                  clr_we_o,
	output logic [RAM_ADDR_W-1:0] clr_addr_o
);

	logic [RAM_ADDR_W-1:0]  cur_addr;
	logic [RAM_ADDR_W-1:0]  end_addr;
	logic [RAM_ADDR_W-1:0]  next_addr;
	logic [ERASE_CNT_W-1:0] step_cnt;
	logic                   step;
	logic                   at_end;

	assign next_addr  = cur_addr + 1'b1;
	assign at_end     = (next_addr == end_addr);
	assign step       = (step_cnt == ERASE_CNT_W'(ERASE_STEP_CYCLES - 1));
	assign clr_addr_o = cur_addr;

	// --------------------------------------------------
	// Pacing and run flag
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_key) begin
			clearing_o <= 1'b0;
			clr_we_o   <= 1'b0;
			step_cnt   <= '0;
		end else begin
			clr_we_o <= 1'b0;
			if (load_done_i) begin
				clearing_o <= 1'b1;
				step_cnt   <= '0;
			end else if (clearing_o) begin
				if (step)
					step_cnt <= '0;
				else
					step_cnt <= step_cnt + 1'b1;
				if (step) begin
					if (at_end)
						clearing_o <= 1'b0;
					else
						clr_we_o <= (next_addr > RAM_ADDR_W'(STUB_LAST_ADDR));
				end
			end
		end
	end

	// Walk pointer, and the address where the walk stops
	always_ff @(posedge clk_sys) begin
		if (load_done_i) begin
			cur_addr <= last_addr_i;
			end_addr <= start_addr_i.word;
		end else if (clearing_o && step && !at_end) begin
			cur_addr <= next_addr;
		end
	end

endmodule

/* design/rk_stream_parser.sv */
// RK stream parser. Bytes are taken only while dl_active_i is high;
// a byte transferred outside a download is dropped.
// dl_ready_o is low while the RAM clear runs.
// load_done_o pulses only if both start address bytes arrived.
// Each write leaves on ld_we_o one cycle after its byte transfers.

`timescale 1ns/1ps

module rk_stream_parser
	import rk_loader_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset_key,
	input  logic                  dl_active_i,
	input  logic [DATA_W-1:0]     dl_index_i,
	input  logic                  dl_valid_i,
	input  logic [DATA_W-1:0]     dl_data_i,
	input  logic                  clearing_i,
	output logic                  dl_ready_o,
	output logic                  ld_we_o,
	output logic                  load_done_o,
	output logic                  loading_o,
	output logic [RAM_ADDR_W-1:0] ld_addr_o,
	output logic [RAM_ADDR_W-1:0] last_addr_o,
	output logic [DATA_W-1:0]     ld_data_o,
	output start_addr_u           start_addr_o
);

	typedef logic [$clog2(HDR_LEN + 1)-1:0] pos_t;

	logic                  active_q;
	logic                  got_start;
	logic                  accept;
	pos_t                  pos_q;
	pos_t                  init_pos;
	pos_t                  cur_pos;
	logic                  wr_req;
	logic [RAM_ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0]     wr_data;
	logic [RAM_ADDR_W-1:0] data_ptr;

	assign dl_ready_o = ~clearing_i;
	assign accept     = dl_valid_i & dl_ready_o & dl_active_i;

	// Covers the gap between the end of the stream and the start of the clear
	assign loading_o = (dl_active_i | active_q | load_done_o) & ~clearing_i;

	// Streams without the sync byte start counting at 1
	assign init_pos = (dl_index_i == SYNC_SKIP_INDEX_A || dl_index_i == SYNC_SKIP_INDEX_B) ?
		pos_t'(1) : pos_t'(0);

	// First byte of a download may arrive on the same edge that sees dl_active_i rise
	assign cur_pos = active_q ? pos_q : init_pos;

	// --------------------------------------------------
	// Position decode
	// --------------------------------------------------
	always_comb begin
		wr_req  = 1'b0;
		wr_addr = data_ptr;
		wr_data = dl_data_i;
		case (cur_pos)
			pos_t'(0): begin
				wr_req = 1'b0;
			end
			pos_t'(1): begin
				wr_req  = 1'b1;
				wr_addr = RAM_ADDR_W'(0);
				wr_data = JMP_OPCODE;
			end
			pos_t'(2): begin
				wr_req  = 1'b1;
				wr_addr = RAM_ADDR_W'(1);
			end
			pos_t'(3): begin
				wr_req  = 1'b1;
				wr_addr = RAM_ADDR_W'(STUB_LAST_ADDR);
				wr_data = start_addr_o.bytes.hi;
			end
			pos_t'(HDR_LEN - 1): begin
				wr_req = 1'b0;
			end
			default: begin
				wr_req = 1'b1;
			end
		endcase
	end

	// Control state
	always_ff @(posedge clk_sys) begin
		if (reset_key) begin
			active_q    <= 1'b0;
			pos_q       <= '0;
			got_start   <= 1'b0;
			ld_we_o     <= 1'b0;
			load_done_o <= 1'b0;
		end else begin
			active_q    <= dl_active_i;
			ld_we_o     <= accept & wr_req;
			load_done_o <= active_q & ~dl_active_i & got_start;
			if (dl_active_i & ~active_q)
				got_start <= 1'b0;
			if (accept) begin
				// Saturate once inside the data section
				if (cur_pos == pos_t'(HDR_LEN))
					pos_q <= cur_pos;
				else
					pos_q <= pos_t'(cur_pos + 1'b1);
				if (cur_pos == pos_t'(2))
					got_start <= 1'b1;
			end else if (!active_q) begin
				// A download may open before its first byte is taken
				pos_q <= init_pos;
			end
		end
	end

	// Start address, data pointer and write payload
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			if (cur_pos == pos_t'(1))
				start_addr_o.bytes.hi <= dl_data_i;
			if (cur_pos == pos_t'(2))
				start_addr_o.bytes.lo <= dl_data_i;
			if (cur_pos == pos_t'(HDR_LEN - 1))
				data_ptr <= start_addr_o.word;
			if (cur_pos == pos_t'(HDR_LEN))
				data_ptr <= data_ptr + 1'b1;
			if (wr_req) begin
				ld_addr_o   <= wr_addr;
				ld_data_o   <= wr_data;
				last_addr_o <= wr_addr;
			end
		end
	end

endmodule

/* design/rk_loader_pkg.sv */
// Shared widths, RK tape format constants and the loader's start address type.
// The RAM is a flat 64 KiB byte space. Addresses wrap at 16 bits.
// The clear step interval assumes internal single-cycle RAM.

package rk_loader_pkg;

	// --------------------------------------------------
	// Widths and depth
	// --------------------------------------------------
	localparam int RAM_ADDR_W = 16;
	localparam int DATA_W     = 8;
	localparam int RAM_WORDS  = 65536;

	// --------------------------------------------------
	// RK format
	// --------------------------------------------------
	// Jump opcode placed at address 0
	localparam logic [DATA_W-1:0] JMP_OPCODE = 8'hC3;
	localparam int STUB_LAST_ADDR = 2;
	// Header occupies stream positions 0 to 4
	localparam int HDR_LEN = 5;

	// These file indexes arrive without the leading sync byte
	localparam logic [DATA_W-1:0] SYNC_SKIP_INDEX_A = 8'h01;
	localparam logic [DATA_W-1:0] SYNC_SKIP_INDEX_B = 8'h41;

	// Clear pacing
	localparam int ERASE_STEP_CYCLES = 4;
	localparam int ERASE_CNT_W       = 2;

	// Start address, filled a byte at a time, used as one word
	typedef union packed {
		logic [RAM_ADDR_W-1:0] word;
		struct packed {
			logic [DATA_W-1:0] hi;
			logic [DATA_W-1:0] lo;
		} bytes;
	} start_addr_u;

endpackage
